// File: common/isaPkg.sv
package isaPkg;

    //////////////////////////////////////////////////////////////////////
    // Instruction set widths
    //////////////////////////////////////////////////////////////////////

    localparam int DataWidth   = 32;  // Register operands and result
    localparam int ImmWidth    = 24;  // Decoder field
    localparam int ShiftBits   = 5;   // Low decoder bits used as shift amount
    localparam int OpcodeWidth = 8;

    //////////////////////////////////////////////////////////////////////
    // Opcodes, values as in the original ALU
    //////////////////////////////////////////////////////////////////////

    typedef enum logic [OpcodeWidth-1:0] {
        OpWait  = 8'd0,    // Stall, PC held
        OpAddIm = 8'd1,
        OpAdd   = 8'd3,
        OpAddC  = 8'd4,    // Add with status carry
        OpSubIm = 8'd5,
        OpSub   = 8'd7,
        OpShl   = 8'd13,
        OpShr   = 8'd15,
        OpAnd   = 8'd17,
        OpNand  = 8'd18,
        OpOr    = 8'd19,
        OpNor   = 8'd20,
        OpXor   = 8'd21,
        OpXnor  = 8'd22,
        OpJp    = 8'd24,   // Unconditional
        OpJeq   = 8'd26,
        OpJg    = 8'd27,
        OpJl    = 8'd28,
        OpCp    = 8'd31,
        OpCpi   = 8'd33,   // Compare against immediate
        OpSor   = 8'd44,
        OpSand  = 8'd45,
        OpSld   = 8'd46,   // Status word to register file
        OpNop   = 8'd255
    } opcode_t;

    // Operation class, decoded once in the capture stage
    typedef enum logic [2:0] {
        ClsNone    = 3'd0,  // NOP, WAIT and unknown codes
        ClsArith   = 3'd1,
        ClsLogic   = 3'd2,
        ClsShift   = 3'd3,
        ClsCompare = 3'd4,
        ClsJump    = 3'd5,
        ClsStatus  = 3'd6
    } opClass_t;

    typedef enum logic [1:0] {
        PcHold = 2'd0,
        PcInc  = 2'd1,
        PcSet  = 2'd3   // Load target
    } pcOp_t;

endpackage

// File: common/busPkg.sv
package busPkg;

    localparam int StatusWidth = 8;

    // Compare codes kept in {cmpHi, cmpLo}
    localparam logic [1:0] RelEqual   = 2'b11;
    localparam logic [1:0] RelGreater = 2'b10;
    localparam logic [1:0] RelLess    = 2'b01;

    //////////////////////////////////////////////////////////////////////
    // Status register views
    //////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic       carry;     // Bit 7, borrow for subtract
        logic       negative;  // Also selects signed compare
        logic [3:0] reserved;
        logic       cmpHi;
        logic       cmpLo;
    } statusFlags_t;

    typedef union packed {
        logic [StatusWidth-1:0] raw;    // SOR, SAND and SLD
        statusFlags_t           flags;  // Arithmetic, compare, jumps
    } statusWord_t;

    //////////////////////////////////////////////////////////////////////
    // Stage buses
    //////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic [isaPkg::DataWidth-1:0] argA;
        logic [isaPkg::DataWidth-1:0] argB;
        logic [isaPkg::ImmWidth-1:0]  imm;
        isaPkg::opcode_t              opcode;
        isaPkg::opClass_t             opClass;
        logic                         useImm;    // Second operand from decoder field
        logic                         subtract;
        logic                         carryIn;   // Adder carry in, already resolved
        statusWord_t                  status;
    } execReq_t;

    typedef struct packed {
        logic [isaPkg::DataWidth-1:0] data;
        logic                         regWrite;
    } wbResult_t;

    typedef struct packed {
        isaPkg::pcOp_t               pcOp;
        logic [isaPkg::ImmWidth-1:0] target;
    } pcCmd_t;

    typedef struct packed {
        logic        write;
        statusWord_t value;
    } srUpdate_t;

endpackage

// File: verilog/operandLatch.sv
`timescale 1ns/1ps

module operandLatch (
    input  logic                         clk,
    input  logic                         rst,
    input  logic [isaPkg::DataWidth-1:0] argA,
    input  logic [isaPkg::DataWidth-1:0] argB,
    input  isaPkg::opcode_t              aluSel,
    input  logic [isaPkg::ImmWidth-1:0]  decoderData,
    input  busPkg::statusWord_t          statusIn,
    output busPkg::execReq_t             req
);
    import isaPkg::*;
    import busPkg::*;

    opClass_t decClass;
    logic     decUseImm;
    logic     decSubtract;
    logic     decCarryIn;

    //////////////////////////////////////////////////////////////////////
    // Opcode decode
    //////////////////////////////////////////////////////////////////////

    always_comb
    begin
        decClass    = ClsNone;
        decUseImm   = 1'b0;
        decSubtract = 1'b0;
        decCarryIn  = 1'b0;
        case (aluSel)
            OpAdd:   decClass = ClsArith;
            OpAddIm:
            begin
                decClass  = ClsArith;
                decUseImm = 1'b1;
            end
            OpAddC:
            begin
                decClass   = ClsArith;
                decCarryIn = statusIn.flags.carry;  // Chained add
            end
            OpSub, OpSubIm:
            begin
                decClass    = ClsArith;
                decUseImm   = (aluSel == OpSubIm);
                decSubtract = 1'b1;
                decCarryIn  = 1'b1;                 // Two's complement +1
            end
            OpAnd, OpNand, OpOr, OpNor, OpXor, OpXnor: decClass = ClsLogic;
            OpShl, OpShr:                              decClass = ClsShift;
            OpCp:                                      decClass = ClsCompare;
            OpCpi:
            begin
                decClass  = ClsCompare;
                decUseImm = 1'b1;
            end
            OpJp, OpJeq, OpJg, OpJl:                   decClass = ClsJump;
            OpSor, OpSand, OpSld:                      decClass = ClsStatus;
            default:                                   decClass = ClsNone;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            req        <= '0;
            req.opcode <= OpWait;  // Idle request holds the PC
        end
        else
        begin
            req.argA     <= argA;
            req.argB     <= argB;
            req.imm      <= decoderData;
            req.opcode   <= aluSel;
            req.opClass  <= decClass;
            req.useImm   <= decUseImm;
            req.subtract <= decSubtract;
            req.carryIn  <= decCarryIn;
            req.status   <= statusIn;
        end
    end

    // A captured jump class must come from one of the jump opcodes
    assert property (@(posedge clk) disable iff (rst)
        (req.opClass == ClsJump) |-> ($past(aluSel) inside {OpJp, OpJeq, OpJg, OpJl}))
        else $error("jump class captured for a non-jump opcode");

endmodule

// File: execute/branchCompare.sv
`timescale 1ns/1ps

module branchCompare (
    input  logic [isaPkg::DataWidth-1:0] lhs,
    input  logic [isaPkg::DataWidth-1:0] rhs,
    input  logic                         signedMode,
    input  busPkg::statusFlags_t         condFlags,
    input  isaPkg::opcode_t              opcode,
    output logic [1:0]                   relation,
    output logic                         jumpTaken
);
    import isaPkg::*;
    import busPkg::*;

    logic       isEqual;
    logic       isGreater;
    logic [1:0] condCode;

    //////////////////////////////////////////////////////////////////////
    // Operand relation
    //////////////////////////////////////////////////////////////////////

    always_comb
    begin
        isEqual = (lhs == rhs);
        if (signedMode)
        begin
            isGreater = ($signed(lhs) > $signed(rhs));  // Negative bit set
        end
        else
        begin
            isGreater = (lhs > rhs);
        end

        if (isEqual)
        begin
            relation = RelEqual;
        end
        else if (isGreater)
        begin
            relation = RelGreater;
        end
        else
        begin
            relation = RelLess;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Jump condition against the stored compare result
    //////////////////////////////////////////////////////////////////////

    assign condCode = {condFlags.cmpHi, condFlags.cmpLo};

    always_comb
    begin
        case (opcode)
            OpJp:    jumpTaken = 1'b1;
            OpJeq:   jumpTaken = (condCode == RelEqual);
            OpJg:    jumpTaken = (condCode == RelGreater);
            OpJl:    jumpTaken = (condCode == RelLess);
            default: jumpTaken = 1'b0;  // Not a jump
        endcase
    end

endmodule

// File: execute/execCore.sv
`timescale 1ns/1ps

module execCore (
    input  logic              clk,
    input  logic              rst,
    input  busPkg::execReq_t  req,
    output busPkg::wbResult_t wbResult,
    output busPkg::pcCmd_t    pcCmd,
    output busPkg::srUpdate_t srUpdate
);
    import isaPkg::*;
    import busPkg::*;

    logic [DataWidth-1:0] opB;
    logic [DataWidth-1:0] addend;
    logic [DataWidth:0]   sum;        // Carry out on top
    logic [DataWidth-1:0] logicRes;
    logic [DataWidth-1:0] shiftRes;
    logic [ShiftBits-1:0] shamt;
    logic [1:0]           relation;
    logic                 jumpTaken;
    wbResult_t            wbNext;
    pcCmd_t               pcNext;
    srUpdate_t            srNext;

    //////////////////////////////////////////////////////////////////////
    // Datapath
    //////////////////////////////////////////////////////////////////////

    assign opB    = req.useImm ? {{(DataWidth-ImmWidth){1'b0}}, req.imm} : req.argB;
    assign addend = req.subtract ? ~opB : opB;
    assign sum    = {1'b0, req.argA} + {1'b0, addend} + {{DataWidth{1'b0}}, req.carryIn};
    assign shamt  = req.imm[ShiftBits-1:0];

    always_comb
    begin
        case (req.opcode)
            OpAnd:   logicRes = req.argA & req.argB;
            OpNand:  logicRes = ~(req.argA & req.argB);
            OpOr:    logicRes = req.argA | req.argB;
            OpNor:   logicRes = ~(req.argA | req.argB);
            OpXor:   logicRes = req.argA ^ req.argB;
            OpXnor:  logicRes = ~(req.argA ^ req.argB);
            default: logicRes = '0;
        endcase
    end

    assign shiftRes = (req.opcode == OpShr) ? (req.argA >> shamt) : (req.argA << shamt);

    branchCompare i_branchCompare (
        .lhs        (req.argA),
        .rhs        (opB),
        .signedMode (req.status.flags.negative),
        .condFlags  (req.status.flags),
        .opcode     (req.opcode),
        .relation   (relation),
        .jumpTaken  (jumpTaken)
    );

    //////////////////////////////////////////////////////////////////////
    // Result, PC command and status update
    //////////////////////////////////////////////////////////////////////

    always_comb
    begin
        wbNext      = '0;
        srNext      = '0;
        pcNext      = '0;
        pcNext.pcOp = PcInc;  // Most opcodes step on
        case (req.opClass)
            ClsArith:
            begin
                wbNext.data                 = sum[DataWidth-1:0];
                wbNext.regWrite             = 1'b1;
                srNext.write                = 1'b1;
                srNext.value                = req.status;
                srNext.value.flags.carry    = sum[DataWidth] ^ req.subtract;  // Borrow
                srNext.value.flags.negative = sum[DataWidth-1];
            end
            ClsLogic:
            begin
                wbNext.data     = logicRes;
                wbNext.regWrite = 1'b1;
            end
            ClsShift:
            begin
                wbNext.data     = shiftRes;
                wbNext.regWrite = 1'b1;
            end
            ClsCompare:
            begin
                srNext.write              = 1'b1;
                srNext.value              = req.status;
                srNext.value.flags.cmpHi  = relation[1];
                srNext.value.flags.cmpLo  = relation[0];
            end
            ClsJump:
            begin
                if (jumpTaken)
                begin
                    pcNext.pcOp   = PcSet;
                    pcNext.target = req.imm;
                end
            end
            ClsStatus:
            begin
                case (req.opcode)
                    OpSor:
                    begin
                        srNext.write     = 1'b1;
                        srNext.value.raw = req.status.raw | req.argA[StatusWidth-1:0];
                    end
                    OpSand:
                    begin
                        srNext.write     = 1'b1;
                        srNext.value.raw = req.status.raw & req.argA[StatusWidth-1:0];
                    end
                    default:  // SLD
                    begin
                        wbNext.data     = {{(DataWidth-StatusWidth){1'b0}}, req.status.raw};
                        wbNext.regWrite = 1'b1;
                    end
                endcase
            end
            default:
            begin
                if (req.opcode == OpWait)
                begin
                    pcNext.pcOp = PcHold;
                end
            end
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            wbResult <= '0;
            pcCmd    <= '0;  // PC held
            srUpdate <= '0;
        end
        else
        begin
            wbResult <= wbNext;
            pcCmd    <= pcNext;
            srUpdate <= srNext;
        end
    end

    // Only arithmetic writes both the register file and the status register
    assert property (@(posedge clk) disable iff (rst)
        (wbResult.regWrite && srUpdate.write) |-> ($past(req.opClass) == ClsArith))
        else $error("register and status write together outside arith");

    // A PC load comes only from a jump request
    assert property (@(posedge clk) disable iff (rst)
        (pcCmd.pcOp == PcSet) |-> ($past(req.opClass) == ClsJump))
        else $error("PC set without a jump request");

endmodule

// File: verilog/aluStage.sv
`timescale 1ns/1ps

module aluStage (
    input  logic                         clk,
    input  logic                         rst,
    input  logic [isaPkg::DataWidth-1:0] argA,
    input  logic [isaPkg::DataWidth-1:0] argB,
    input  isaPkg::opcode_t              aluSel,
    input  logic [isaPkg::ImmWidth-1:0]  decoderData,
    input  busPkg::statusWord_t          statusIn,
    output busPkg::wbResult_t            wbResult,
    output busPkg::pcCmd_t               pcCmd,
    output busPkg::srUpdate_t            srUpdate
);
    import busPkg::*;

    execReq_t req;  // Capture register to execute

    //////////////////////////////////////////////////////////////////////
    // Two-cycle execute pipeline
    //////////////////////////////////////////////////////////////////////

    operandLatch i_operandLatch (
        .clk         (clk),
        .rst         (rst),
        .argA        (argA),
        .argB        (argB),
        .aluSel      (aluSel),
        .decoderData (decoderData),
        .statusIn    (statusIn),
        .req         (req)
    );

    execCore i_execCore (
        .clk      (clk),
        .rst      (rst),
        .req      (req),
        .wbResult (wbResult),
        .pcCmd    (pcCmd),
        .srUpdate (srUpdate)
    );

endmodule

// File: verification/aluTbTasks.svh
`ifndef ALU_TB_TASKS_SVH
`define ALU_TB_TASKS_SVH

//////////////////////////////////////////////////////////////////////
// Compare tasks, one per output bus
//////////////////////////////////////////////////////////////////////

task automatic checkWb(input string name, input wbResult_t exp, input wbResult_t act);
    checkCount++;
    if (act !== exp)
    begin
        errorCount++;
        $display("FAIL %s: wbResult expected data=%h regWrite=%b, actual data=%h regWrite=%b",
                 name, exp.data, exp.regWrite, act.data, act.regWrite);
    end
endtask

task automatic checkPc(input string name, input pcCmd_t exp, input pcCmd_t act);
    checkCount++;
    if (act !== exp)
    begin
        errorCount++;
        $display("FAIL %s: pcCmd expected pcOp=%0d target=%h, actual pcOp=%0d target=%h",
                 name, exp.pcOp, exp.target, act.pcOp, act.target);
    end
endtask

task automatic checkSr(input string name, input srUpdate_t exp, input srUpdate_t act);
    checkCount++;
    if (act !== exp)
    begin
        errorCount++;
        $display("FAIL %s: srUpdate expected write=%b value=%h, actual write=%b value=%h",
                 name, exp.write, exp.value.raw, act.write, act.value.raw);
    end
endtask

//////////////////////////////////////////////////////////////////////
// Reference model of the result rules
//////////////////////////////////////////////////////////////////////

function automatic void refModel(input opcode_t op, input logic [31:0] a, input logic [31:0] b,
                                 input logic [23:0] imm, input statusWord_t st,
                                 output wbResult_t wb, output pcCmd_t pc, output srUpdate_t sr);
    logic [31:0] opB;
    logic [32:0] wide;
    logic [1:0]  rel;
    logic        isGreater;
    logic        cin;
    wb      = '0;
    pc      = '0;
    sr      = '0;
    pc.pcOp = PcInc;
    opB     = (op inside {OpAddIm, OpSubIm, OpCpi}) ? {8'h00, imm} : b;
    cin     = (op == OpAddC) ? st.flags.carry : 1'b0;
    case (op)
        OpAdd, OpAddIm, OpAddC:
        begin
            wide                    = {1'b0, a} + {1'b0, opB} + {32'h0, cin};
            wb                      = '{data: wide[31:0], regWrite: 1'b1};
            sr.write                = 1'b1;
            sr.value                = st;
            sr.value.flags.carry    = wide[32];
            sr.value.flags.negative = wide[31];
        end
        OpSub, OpSubIm:
        begin
            wb                      = '{data: a - opB, regWrite: 1'b1};
            sr.write                = 1'b1;
            sr.value                = st;
            sr.value.flags.carry    = (a < opB);  // Borrow
            sr.value.flags.negative = wb.data[31];
        end
        OpAnd:  wb = '{data: a & b, regWrite: 1'b1};
        OpNand: wb = '{data: ~(a & b), regWrite: 1'b1};
        OpOr:   wb = '{data: a | b, regWrite: 1'b1};
        OpNor:  wb = '{data: ~(a | b), regWrite: 1'b1};
        OpXor:  wb = '{data: a ^ b, regWrite: 1'b1};
        OpXnor: wb = '{data: ~(a ^ b), regWrite: 1'b1};
        OpShl:  wb = '{data: a << imm[4:0], regWrite: 1'b1};
        OpShr:  wb = '{data: a >> imm[4:0], regWrite: 1'b1};
        OpCp, OpCpi:
        begin
            isGreater = st.flags.negative ? ($signed(a) > $signed(opB)) : (a > opB);
            rel       = (a == opB) ? 2'b11 : (isGreater ? 2'b10 : 2'b01);
            sr.write  = 1'b1;
            sr.value  = st;
            sr.value.flags.cmpHi = rel[1];
            sr.value.flags.cmpLo = rel[0];
        end
        OpJp:  pc = '{pcOp: PcSet, target: imm};
        OpJeq: if ({st.flags.cmpHi, st.flags.cmpLo} == 2'b11) pc = '{pcOp: PcSet, target: imm};
        OpJg:  if ({st.flags.cmpHi, st.flags.cmpLo} == 2'b10) pc = '{pcOp: PcSet, target: imm};
        OpJl:  if ({st.flags.cmpHi, st.flags.cmpLo} == 2'b01) pc = '{pcOp: PcSet, target: imm};
        OpSor:
        begin
            sr.write     = 1'b1;
            sr.value.raw = st.raw | a[7:0];
        end
        OpSand:
        begin
            sr.write     = 1'b1;
            sr.value.raw = st.raw & a[7:0];
        end
        OpSld:  wb = '{data: {24'h0, st.raw}, regWrite: 1'b1};
        OpWait: pc.pcOp = PcHold;
        default: ;  // NOP and unknown codes step the PC
    endcase
endfunction

//////////////////////////////////////////////////////////////////////
// Drive helpers and directed tests
//////////////////////////////////////////////////////////////////////

task automatic driveInputs(input opcode_t op, input logic [31:0] a, input logic [31:0] b,
                           input logic [23:0] imm, input statusWord_t st);
    aluSel      = op;
    argA        = a;
    argB        = b;
    decoderData = imm;
    statusIn    = st;
endtask

task automatic execAndCheck(input string name, input opcode_t op, input logic [31:0] a,
                            input logic [31:0] b, input logic [23:0] imm,
                            input statusWord_t st);
    wbResult_t expWb;
    pcCmd_t    expPc;
    srUpdate_t expSr;
    driveInputs(op, a, b, imm, st);
    refModel(op, a, b, imm, st, expWb, expPc, expSr);
    @(posedge clk);  // Capture
    @(posedge clk);  // Result registered
    @(negedge clk);
    checkWb(name, expWb, wbResult);
    checkPc(name, expPc, pcCmd);
    checkSr(name, expSr, srUpdate);
endtask

task automatic finishTest(input string name, input int errorsBefore);
    testCount++;
    if (errorCount == errorsBefore)
        $display("Test %s done, no mismatches", name);
    else
        $display("Test %s done, %0d mismatches", name, errorCount - errorsBefore);
endtask

task automatic resetBehavior(output logic released);
    wbResult_t idleWb;
    pcCmd_t    idlePc;
    srUpdate_t idleSr;
    int        waited;
    int        errorsBefore;
    errorsBefore = errorCount;
    idleWb       = '0;
    idlePc       = '0;  // PC hold
    idleSr       = '0;
    waited       = 0;
    released     = 1'b0;
    // Outputs idle under reset and for one cycle after release
    while (!released && waited < ResetTimeout)
    begin
        @(negedge clk);
        waited++;
        checkWb("reset", idleWb, wbResult);
        checkPc("reset", idlePc, pcCmd);
        checkSr("reset", idleSr, srUpdate);
        released = !rst;
    end
    finishTest("reset", errorsBefore);
endtask

task automatic arithEdges();
    int errorsBefore;
    errorsBefore = errorCount;
    execAndCheck("add overflow", OpAdd, 32'hffff_ffff, 32'h0000_0001, 24'h0, 8'h3c);
    execAndCheck("add sign", OpAdd, 32'h7fff_ffff, 32'h0000_0001, 24'h0, 8'h00);
    execAndCheck("addc carry in", OpAddC, 32'h0000_0001, 32'h0000_0001, 24'h0, 8'h80);
    execAndCheck("addc overflow", OpAddC, 32'hffff_fffe, 32'h0000_0001, 24'h0, 8'h83);
    execAndCheck("addim carry", OpAddIm, 32'hffff_fff0, 32'h0, 24'h00_0020, 8'h00);
    execAndCheck("sub borrow", OpSub, 32'h0, 32'h0000_0001, 24'h0, 8'h00);
    execAndCheck("sub plain", OpSub, 32'h0000_0005, 32'h0000_0003, 24'h0, 8'hbc);
    execAndCheck("subim borrow", OpSubIm, 32'h0000_0010, 32'h0, 24'hff_ffff, 8'h00);
    finishTest("arith", errorsBefore);
endtask

task automatic logicShift();
    opcode_t     logicOps [6];
    logic [4:0]  amounts [3];
    logic [31:0] a;
    logic [31:0] b;
    int          errorsBefore;
    logicOps     = '{OpAnd, OpNand, OpOr, OpNor, OpXor, OpXnor};
    amounts      = '{5'd0, 5'd1, 5'd31};
    errorsBefore = errorCount;
    a            = nextRandom();
    b            = nextRandom();
    foreach (logicOps[i])
        execAndCheck($sformatf("logic %0d", logicOps[i]), logicOps[i], a, b, 24'h0, 8'h00);
    foreach (amounts[i])
    begin
        execAndCheck($sformatf("shl %0d", amounts[i]), OpShl, 32'hc000_0005, b,
                     24'habcde0 | {19'h0, amounts[i]}, 8'h00);
        execAndCheck($sformatf("shr %0d", amounts[i]), OpShr, 32'hc000_0005, b,
                     24'habcde0 | {19'h0, amounts[i]}, 8'h00);
    end
    finishTest("logic and shift", errorsBefore);
endtask

task automatic compareJump();
    opcode_t     jumpOps [3];
    statusWord_t st;
    int          code;
    int          errorsBefore;
    jumpOps      = '{OpJeq, OpJg, OpJl};
    errorsBefore = errorCount;
    execAndCheck("cp equal", OpCp, 32'h0000_0005, 32'h0000_0005, 24'h0, 8'h00);
    execAndCheck("cp unsigned greater", OpCp, 32'h8000_0000, 32'h0000_0001, 24'h0, 8'h00);
    execAndCheck("cp unsigned less", OpCp, 32'h0000_0001, 32'h0000_0002, 24'h0, 8'h03);
    execAndCheck("cp signed less", OpCp, 32'h8000_0000, 32'h0000_0001, 24'h0, 8'h40);
    execAndCheck("cp signed greater", OpCp, 32'h0000_0001, 32'hffff_ffff, 24'h0, 8'h40);
    execAndCheck("cpi equal", OpCpi, 32'h0012_3456, 32'h0, 24'h12_3456, 8'h00);
    execAndCheck("cpi unsigned", OpCpi, 32'hffff_fff0, 32'h0, 24'h00_0005, 8'h00);
    execAndCheck("cpi signed", OpCpi, 32'hffff_fff0, 32'h0, 24'h00_0005, 8'h40);
    execAndCheck("jp", OpJp, 32'h0, 32'h0, 24'h12_3456, 8'h00);
    foreach (jumpOps[i])
    begin
        for (code = 0; code < 4; code++)
        begin
            st.raw = {6'b0, code[1:0]};  // Stored compare bits
            execAndCheck($sformatf("jump %0d code %0d", jumpOps[i], code), jumpOps[i],
                         32'h0, 32'h0, 24'h00_0abc, st);
        end
    end
    finishTest("compare and jump", errorsBefore);
endtask

task automatic statusOps();
    int errorsBefore;
    errorsBefore = errorCount;
    execAndCheck("sor", OpSor, 32'hffff_ff42, 32'h0, 24'h0, 8'h81);
    execAndCheck("sand", OpSand, 32'h0000_003c, 32'h0, 24'h0, 8'hf0);
    execAndCheck("sld", OpSld, 32'h0, 32'h0, 24'h0, 8'ha5);
    execAndCheck("wait", OpWait, 32'h1234_5678, 32'h9abc_def0, 24'h00_0042, 8'h13);
    execAndCheck("nop", OpNop, 32'h1234_5678, 32'h9abc_def0, 24'h00_0042, 8'h13);
    execAndCheck("unknown opcode", opcode_t'(8'd99), 32'h1, 32'h2, 24'h00_0042, 8'h13);
    finishTest("status", errorsBefore);
endtask

`endif

// File: verification/aluStageTb.sv
`timescale 1ns/1ps

module aluStageTb;
    import isaPkg::*;
    import busPkg::*;

    localparam int ResetTimeout = 20;    // Cycles to see rst low
    localparam int MaxCycles    = 5000;  // Watchdog
    localparam int RandomCount  = 200;

    logic                 clk = 1'b0;
    logic                 rst = 1'b1;
    logic [DataWidth-1:0] argA;
    logic [DataWidth-1:0] argB;
    opcode_t              aluSel;
    logic [ImmWidth-1:0]  decoderData;
    statusWord_t          statusIn;
    wbResult_t            wbResult;
    pcCmd_t               pcCmd;
    srUpdate_t            srUpdate;

    int          errorCount = 0;
    int          checkCount = 0;
    int          testCount  = 0;
    logic [31:0] rngState   = 32'h986f_23c8;

    aluStage i_aluStage (
        .clk         (clk),
        .rst         (rst),
        .argA        (argA),
        .argB        (argB),
        .aluSel      (aluSel),
        .decoderData (decoderData),
        .statusIn    (statusIn),
        .wbResult    (wbResult),
        .pcCmd       (pcCmd),
        .srUpdate    (srUpdate)
    );

    always #4 clk = ~clk;  // 8 ns period

    initial
    begin
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst <= 1'b0;  // Seen by the main sequence one falling edge later
    end

    initial
    begin
        repeat (MaxCycles) @(posedge clk);
        $display("Simulation did not finish within %0d cycles", MaxCycles);
        $display("Testbench failed");
        $finish;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] state);
        logic [31:0] x;
        x = state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] nextRandom();
        rngState = xorshift32(rngState);
        return rngState;
    endfunction

    `include "aluTbTasks.svh"

    //////////////////////////////////////////////////////////////////////
    // Back-to-back random stream, one instruction per cycle
    //////////////////////////////////////////////////////////////////////

    task automatic randomStream();
        opcode_t     keptOps [24];
        wbResult_t   expWbQ [$];
        pcCmd_t      expPcQ [$];
        srUpdate_t   expSrQ [$];
        wbResult_t   expWb;
        pcCmd_t      expPc;
        srUpdate_t   expSr;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] r;
        statusWord_t st;
        opcode_t     op;
        string       name;
        int          cycle;
        int          errorsBefore;
        keptOps = '{OpWait, OpAddIm, OpAdd, OpAddC, OpSubIm, OpSub, OpShl, OpShr,
                    OpAnd, OpNand, OpOr, OpNor, OpXor, OpXnor, OpJp, OpJeq,
                    OpJg, OpJl, OpCp, OpCpi, OpSor, OpSand, OpSld, OpNop};
        errorsBefore = errorCount;
        for (cycle = 0; cycle < RandomCount + 2; cycle++)
        begin
            if (cycle >= 2)  // Result of the instruction two cycles back
            begin
                name  = $sformatf("random[%0d]", cycle - 2);
                expWb = expWbQ.pop_front();
                expPc = expPcQ.pop_front();
                expSr = expSrQ.pop_front();
                checkWb(name, expWb, wbResult);
                checkPc(name, expPc, pcCmd);
                checkSr(name, expSr, srUpdate);
            end
            if (cycle < RandomCount)
            begin
                op = keptOps[int'(nextRandom() % 32'd24)];
                a  = nextRandom();
                b  = nextRandom();
                r  = nextRandom();
                if (r[26:24] == 3'd0)
                begin
                    b = a;  // Some equal compares
                end
                st.raw = r[31:24];
                driveInputs(op, a, b, r[23:0], st);
                refModel(op, a, b, r[23:0], st, expWb, expPc, expSr);
                expWbQ.push_back(expWb);
                expPcQ.push_back(expPc);
                expSrQ.push_back(expSr);
            end
            else
            begin
                driveInputs(OpWait, '0, '0, '0, '0);
            end
            @(negedge clk);
        end
        finishTest("random stream", errorsBefore);
    endtask

    initial
    begin
        logic released;
        argA        = 32'h1234_5678;  // ADD held at the inputs through reset
        argB        = 32'h0000_0001;
        aluSel      = OpAdd;
        decoderData = 24'h00_0abc;
        statusIn    = 8'h83;
        resetBehavior(released);

        if (!released)
        begin
            $display("Reset was still high after %0d cycles", ResetTimeout);
            $display("Testbench failed");
            $finish;
        end
        else
        begin
            arithEdges();
            logicShift();
            compareJump();
            statusOps();
            randomStream();
            $display("Tests %0d, checks %0d, errors %0d", testCount, checkCount, errorCount);
            if (errorCount == 0)
            begin
                $display("Testbench passed");
            end
            else
            begin
                $display("Testbench failed");
            end
            $finish;
        end
    end

endmodule

// File: src.f
+incdir+verification
common/isaPkg.sv
common/busPkg.sv
verilog/operandLatch.sv
execute/branchCompare.sv
execute/execCore.sv
verilog/aluStage.sv
verification/aluStageTb.sv

// File: run.sh
#!/usr/bin/env bash
# Builds the execute stage testbench with Verilator, runs it and scans the log

set -o pipefail
cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing --assert -j 0 -f src.f --top-module aluStageTb -o aluStageSim \
    && ./obj_dir/aluStageSim | tee sim.log \
    || { echo "run.sh: build or simulation error"; exit 1; }

grep -q "Testbench failed" sim.log \
    && { echo "run.sh: failure reported in sim.log"; exit 1; } \
    || echo "run.sh: no failure reported"
